// File: common/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// ##################################################
// Panel geometry.
// ##################################################
// Visible pixels per line.
`define LCD_WIDTH 240
// Visible lines per frame.
`define LCD_HEIGHT 160
// Width of the pixel column and line indexes.
`define LCD_XY_W 8

// ##################################################
// Controller sequencing.
// ##################################################
// Sequencing counter, sets the start-up length.
`define LCD_COUNT_W 17
// System reset command byte.
`define LCD_CMD_RESET 8'he2

// Gray level per 2-bit pixel value.
`define LCD_GRAY0 4'd0
`define LCD_GRAY1 4'd2
`define LCD_GRAY2 4'd7
`define LCD_GRAY3 4'd15

// Video timing, all in clock cycles or strobe periods.
`define LCD_PX_GAP 4
`define LCD_HBLANK 8
`define LCD_VBLANK 64

`endif

// File: common/lcd_pkg.sv
package lcd_pkg;

	// ##################################################
	// Controller state.
	// ##################################################
	typedef enum logic [1:0] {
		state_off    = 2'd0,
		state_init   = 2'd1,
		state_on     = 2'd2,
		state_uninit = 2'd3
	} ctrl_state_t;

	// ##################################################
	// Pixel stream into the controller.
	// ##################################################
	// One-cycle strobes plus the pixel value.
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       px_out;
		// Valid only with px_out.
		logic [1:0] px;
	} px_stream_t;

	// ##################################################
	// LCD write bus.
	// ##################################################
	// Command byte when cd is low, pixel pair when cd is high.
	typedef union packed {
		logic [7:0] cmd;
		struct packed {
			// Gray level of the odd pixel.
			logic [3:0] odd;
			// Gray level of the even pixel.
			logic [3:0] even;
		} px;
	} lcd_byte_u;

	// Panel latches data and cd whenever write is high.
	typedef struct packed {
		lcd_byte_u data;
		logic      cd;
		logic      write;
	} lcd_bus_t;

endpackage

// File: rtl/video_timing.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module video_timing import lcd_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	output px_stream_t           stream,
	output logic [`LCD_XY_W-1:0] x,
	output logic [`LCD_XY_W-1:0] y
);

	localparam int XW         = `LCD_XY_W;
	localparam int LINE_SLOTS = `LCD_WIDTH + `LCD_HBLANK;

	// Cycle counter inside one strobe period.
	logic [7:0]    r_gap;
	// Strobe slot inside a line or inside the vertical blank.
	logic [XW-1:0] r_col;
	// Line index, equal to LCD_HEIGHT during vertical blank.
	logic [XW-1:0] r_row;

	logic slot;
	logic vblank;

	// One strobe slot at the start of each period.
	assign slot   = (r_gap == '0);
	assign vblank = (r_row == XW'(`LCD_HEIGHT));

	// ##################################################
	// Strobe decode.
	// ##################################################
	always_comb begin
		stream        = '0;
		// Visible columns of an active line.
		stream.px_out = slot && !vblank && (r_col < XW'(`LCD_WIDTH));
		// First blank slot after the last pixel.
		stream.hsync  = slot && !vblank && (r_col == XW'(`LCD_WIDTH));
		// First slot of the vertical blank.
		stream.vsync  = slot && vblank && (r_col == '0);
	end

	// Position of the current strobe.
	assign x = r_col;
	assign y = r_row;

	// ##################################################
	// Counters.
	// ##################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			r_gap <= '0;
			r_col <= '0;
			r_row <= '0;
		end else if (r_gap == 8'(`LCD_PX_GAP - 1)) begin
			r_gap <= '0;
			if (!vblank) begin
				// Line end wraps the column, steps the line.
				if (r_col == XW'(LINE_SLOTS - 1)) begin
					r_col <= '0;
					r_row <= r_row + 1'b1;
				end else begin
					r_col <= r_col + 1'b1;
				end
			end else if (r_col == XW'(`LCD_VBLANK - 1)) begin
				// Blank done, back to line 0.
				r_col <= '0;
				r_row <= '0;
			end else begin
				r_col <= r_col + 1'b1;
			end
		end else begin
			r_gap <= r_gap + 1'b1;
		end
	end

endmodule

// File: rtl/pattern_gen.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module pattern_gen import lcd_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  px_stream_t           stream_in,
	input  logic [`LCD_XY_W-1:0] x,
	input  logic [`LCD_XY_W-1:0] y,
	output px_stream_t           stream_out
);

	// Frames seen since reset, modulo 4.
	logic [1:0] r_frame;
	logic [1:0] px;

	// ##################################################
	// Pixel rule.
	// ##################################################
	// Bands 8 columns wide, shifted per line and per frame.
	// Two-bit sum wraps modulo 4.
	assign px = x[4:3] + y[1:0] + r_frame;

	// ##################################################
	// Output register.
	// ##################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			r_frame           <= '0;
			stream_out.hsync  <= 1'b0;
			stream_out.vsync  <= 1'b0;
			stream_out.px_out <= 1'b0;
		end else begin
			// Strobes delayed by one cycle.
			stream_out.hsync  <= stream_in.hsync;
			stream_out.vsync  <= stream_in.vsync;
			stream_out.px_out <= stream_in.px_out;
			// Next frame starts after vsync.
			if (stream_in.vsync) begin
				r_frame <= r_frame + 1'b1;
			end
		end
		// Pixel value aligned with its strobe.
		stream_out.px <= px;
	end

endmodule

// File: uc1611/uc1611_ctrl.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module uc1611_ctrl import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       disp_on,
	input  px_stream_t stream,
	output lcd_bus_t   bus
);

	localparam int CW = `LCD_COUNT_W;

	// Registered and next state, reference style.
	ctrl_state_t r_state;
	ctrl_state_t state;
	logic [CW-1:0] r_count;
	logic [CW-1:0] count;

	logic       r_insync;
	logic       insync;
	logic       r_oddpx;
	logic       oddpx;
	// Gray level of the buffered even pixel.
	logic [3:0] r_pxbuf;
	logic [3:0] pxbuf;

	lcd_byte_u r_lcd_data;
	lcd_byte_u lcd_data;
	logic      r_lcd_cd;
	logic      lcd_cd;
	logic      lcd_write;

	// ##################################################
	// Init command ROM.
	// ##################################################
	function automatic logic [7:0] init_rom(input logic [3:0] idx);
		case (idx)
			// Mapping control, MY=1 MX=1.
			4'd0:    init_rom = 8'hc6;
			// Line rate 23.2 kHz.
			4'd1:    init_rom = 8'ha1;
			// Panel loading 28 to 40 nF.
			4'd2:    init_rom = 8'h2a;
			// Gray scale, 16 levels.
			4'd3:    init_rom = 8'hd2;
			// Bias ratio 11.
			4'd4:    init_rom = 8'hea;
			// Gain and potentiometer, two bytes.
			4'd5:    init_rom = 8'h81;
			4'd6:    init_rom = 8'h00;
			// Partial display off.
			4'd7:    init_rom = 8'h84;
			// RAM address, page first then column.
			4'd8:    init_rom = 8'h8b;
			// Enable all column sets.
			4'd9:    init_rom = 8'haf;
			// Scroll line zero.
			4'd10:   init_rom = 8'h40;
			4'd11:   init_rom = 8'h50;
			// Page and column zero, resent every frame.
			4'd12:   init_rom = 8'h60;
			4'd13:   init_rom = 8'h70;
			4'd14:   init_rom = 8'h00;
			default: init_rom = 8'h10;
		endcase
	endfunction

	// Two-bit pixel to panel gray level.
	function automatic logic [3:0] gray_of(input logic [1:0] p);
		case (p)
			2'd0:    gray_of = `LCD_GRAY0;
			2'd1:    gray_of = `LCD_GRAY1;
			2'd2:    gray_of = `LCD_GRAY2;
			default: gray_of = `LCD_GRAY3;
		endcase
	endfunction

	// ##################################################
	// Next-state logic.
	// ##################################################
	always_comb begin
		state     = r_state;
		count     = r_count;
		insync    = r_insync;
		oddpx     = r_oddpx;
		pxbuf     = r_pxbuf;
		lcd_data  = r_lcd_data;
		lcd_cd    = r_lcd_cd;
		lcd_write = 1'b0;

		case (r_state)
			state_off: begin
				if (disp_on) begin
					state        = state_init;
					count        = '0;
					lcd_cd       = 1'b0;
					// Reset byte, written on count 0.
					lcd_data.cmd = `LCD_CMD_RESET;
					insync       = 1'b1;
					oddpx        = 1'b0;
				end
			end
			state_init: begin
				if (r_count[CW-1:1] == '0) begin
					lcd_write = !r_count[0];
				end else if (r_count[CW-1:1] == (CW-1)'(1)) begin
					// Set up zero bytes for the RAM clear.
					lcd_cd       = 1'b1;
					lcd_data.cmd = 8'h00;
				end else if (!(&r_count[CW-1:CW-2])) begin
					// RAM clear, one write every other cycle.
					lcd_write = !r_count[0];
				end
				// Command mode ahead of the ROM phase.
				if (r_count[CW-1:CW-5] == 5'b11100) begin
					lcd_cd = 1'b0;
				end
				// ROM phase, one command every two cycles.
				if (&r_count[CW-1:CW-4]) begin
					lcd_write = !r_count[0];
					if (lcd_write) begin
						lcd_data.cmd = init_rom(r_count[4:1]);
					end
					if (r_count[0] && r_count[4:1] == 4'd15) begin
						state = state_on;
					end
				end
				// Sync tracking while commands go out.
				if (stream.vsync) begin
					insync = 1'b1;
				end else if (stream.hsync || stream.px_out) begin
					insync = 1'b0;
				end
				count = r_count + 1'b1;
			end
			state_on: begin
				if (!disp_on) begin
					state        = state_uninit;
					count[0]     = 1'b0;
					lcd_cd       = 1'b0;
					lcd_data.cmd = `LCD_CMD_RESET;
				end else if (stream.vsync) begin
					// Skip reset, clear and wait, resend ROM 12 to 15.
					state  = state_init;
					count  = {4'b1111, (CW-9)'(0), 4'd12, 1'b0};
					lcd_cd = 1'b0;
					insync = 1'b1;
					oddpx  = 1'b0;
				end
			end
			default: begin
				// Reset byte on the first cycle, then off.
				lcd_write = !r_count[0];
				if (r_count[0]) begin
					state = state_off;
				end
				count[0] = 1'b1;
			end
		endcase

		// ##################################################
		// Pixel packer.
		// ##################################################
		if (state == state_on && insync) begin
			lcd_cd = 1'b1;
			if (stream.px_out) begin
				if (!r_oddpx) begin
					// Even pixel, hold it.
					oddpx = 1'b1;
					pxbuf = gray_of(stream.px);
				end else begin
					// Odd pixel completes the pair.
					oddpx            = 1'b0;
					lcd_data.px.even = r_pxbuf;
					lcd_data.px.odd  = gray_of(stream.px);
					lcd_write        = 1'b1;
				end
			end
		end
	end

	assign bus.data  = lcd_data;
	assign bus.cd    = lcd_cd;
	assign bus.write = lcd_write;

	// ##################################################
	// State registers.
	// ##################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			r_state  <= state_off;
			r_count  <= '0;
			r_insync <= 1'b0;
			r_oddpx  <= 1'b0;
		end else begin
			r_state  <= state;
			r_count  <= count;
			r_insync <= insync;
			r_oddpx  <= oddpx;
		end
		r_pxbuf    <= pxbuf;
		r_lcd_data <= lcd_data;
		r_lcd_cd   <= lcd_cd;
	end

endmodule

// File: rtl/lcd_top.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_top import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       disp_on,
	output logic [7:0] lcd_data,
	output logic       lcd_cd,
	output logic       lcd_write,
	output logic       lcd_cs,
	output logic       lcd_read,
	output logic       lcd_vled
);

	// Raw strobes and coordinates from the timing block.
	px_stream_t           timing_stream;
	logic [`LCD_XY_W-1:0] x;
	logic [`LCD_XY_W-1:0] y;
	// Complete stream into the controller.
	px_stream_t           pattern_stream;
	lcd_bus_t             bus;

	// ##################################################
	// Pixel source.
	// ##################################################
	video_timing timing_i (
		.clk    (clk),
		.reset  (reset),
		.stream (timing_stream),
		.x      (x),
		.y      (y)
	);

	pattern_gen pattern_i (
		.clk        (clk),
		.reset      (reset),
		.stream_in  (timing_stream),
		.x          (x),
		.y          (y),
		.stream_out (pattern_stream)
	);

	// ##################################################
	// Panel controller.
	// ##################################################
	uc1611_ctrl ctrl_i (
		.clk     (clk),
		.reset   (reset),
		.disp_on (disp_on),
		.stream  (pattern_stream),
		.bus     (bus)
	);

	// Panel pins.
	assign lcd_data  = bus.data;
	assign lcd_cd    = bus.cd;
	assign lcd_write = bus.write;
	// Write-only bus, chip always selected.
	assign lcd_cs    = 1'b1;
	assign lcd_read  = 1'b0;
	// Backlight follows the display enable.
	assign lcd_vled  = disp_on;

endmodule

// File: verification/lcd_props.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_props import lcd_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        disp_on,
	input logic [7:0]  lcd_data,
	input logic        lcd_cd,
	input logic        lcd_write,
	input logic        lcd_cs,
	input logic        lcd_read,
	input logic        lcd_vled,
	input ctrl_state_t state
);

	// Failed assertions, read by the testbench.
	int unsigned fail_count = 0;

	// ##################################################
	// Constant pins.
	// ##################################################
	a_pins: assert property (@(posedge clk) disable iff (reset)
		lcd_cs && !lcd_read && (lcd_vled == disp_on))
		else begin
			$error("Constant panel pins wrong");
			fail_count++;
		end

	// Write strobes last one cycle.
	a_pulse: assert property (@(posedge clk) disable iff (reset)
		lcd_write |=> !lcd_write)
		else begin
			$error("Write held longer than one cycle");
			fail_count++;
		end

	// ##################################################
	// Start and shutdown commands.
	// ##################################################
	a_start: assert property (@(posedge clk) disable iff (reset)
		(state == state_off && disp_on) |=>
			(lcd_write && !lcd_cd && lcd_data == `LCD_CMD_RESET))
		else begin
			$error("Missing reset command at start-up");
			fail_count++;
		end

	a_shutdown: assert property (@(posedge clk) disable iff (reset)
		(state == state_on && !disp_on) |=>
			(lcd_write && !lcd_cd && lcd_data == `LCD_CMD_RESET) ##1 !lcd_write)
		else begin
			$error("Missing reset command at shutdown");
			fail_count++;
		end

	// Pixel writes in the on state are data.
	a_pixel_cd: assert property (@(posedge clk) disable iff (reset)
		(state == state_on && disp_on && lcd_write) |-> lcd_cd)
		else begin
			$error("Pixel write with cd low");
			fail_count++;
		end

endmodule

bind lcd_top lcd_props props_i (
	.clk       (clk),
	.reset     (reset),
	.disp_on   (disp_on),
	.lcd_data  (lcd_data),
	.lcd_cd    (lcd_cd),
	.lcd_write (lcd_write),
	.lcd_cs    (lcd_cs),
	.lcd_read  (lcd_read),
	.lcd_vled  (lcd_vled),
	.state     (ctrl_i.r_state)
);

// File: verification/lcd_tb.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_tb;

	localparam int LONG_WAIT  = 200000;
	localparam int PAIRS      = `LCD_WIDTH / 2;
	// Vertical blank ahead of the first pixel pair of a frame.
	localparam int BLANK_WAIT = 2 * `LCD_VBLANK * `LCD_PX_GAP;

	logic       clk;
	logic       reset;
	logic       disp_on;
	logic [7:0] lcd_data;
	logic       lcd_cd;
	logic       lcd_write;
	logic       lcd_cs;
	logic       lcd_read;
	logic       lcd_vled;

	int unsigned check_fails = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          frame_no = 0;
	logic [7:0]  rom [16] = '{8'hc6, 8'ha1, 8'h2a, 8'hd2, 8'hea, 8'h81, 8'h00, 8'h84,
		8'h8b, 8'haf, 8'h40, 8'h50, 8'h60, 8'h70, 8'h00, 8'h10};
	logic [3:0]  gray [4] = '{4'd0, 4'd2, 4'd7, 4'd15};

	lcd_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.disp_on   (disp_on),
		.lcd_data  (lcd_data),
		.lcd_cd    (lcd_cd),
		.lcd_write (lcd_write),
		.lcd_cs    (lcd_cs),
		.lcd_read  (lcd_read),
		.lcd_vled  (lcd_vled)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ##################################################
	// Helpers.
	// ##################################################
	function automatic int all_fails();
		return check_fails + dut_i.props_i.fail_count;
	endfunction

	task automatic expect_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("FAILED %0t: %s", $time, msg);
			check_fails++;
		end
	endtask

	// Next monitored write, sampled mid-cycle.
	task automatic next_write(input int limit, output logic [7:0] d, output logic c);
		int n;
		n = 0;
		@(negedge clk);
		while (!lcd_write) begin
			n++;
			if (n > limit) begin
				$display("Timed out waiting for an LCD write");
				$display("Simulation failed");
				$finish;
			end
			@(negedge clk);
		end
		d = lcd_data;
		c = lcd_cd;
	endtask

	task automatic report(input string name, input int start_fails);
		if (all_fails() == start_fails) begin
			tests_passed++;
			$display("Test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAIL", name);
		end
	endtask

	// Page and column re-address after vsync.
	task automatic check_readdress();
		logic [7:0] d;
		logic       c;
		int         start;
		start = all_fails();
		for (int i = 0; i < 4; i++) begin
			next_write(LONG_WAIT, d, c);
			expect_true(!c && d == rom[12 + i], "re-address command wrong");
		end
		frame_no++;
		report("frame re-address", start);
	endtask

	// Pixel pairs in raster order from the write count.
	task automatic check_pixels(input int count);
		logic [7:0] d;
		logic       c;
		int         start;
		int         x;
		int         y;
		start = all_fails();
		for (int n = 0; n < count; n++) begin
			y = n / PAIRS;
			x = 2 * (n % PAIRS);
			next_write((n == 0) ? BLANK_WAIT : 64, d, c);
			expect_true(c, "pixel write with cd low");
			expect_true(d == {gray[((x + 1) / 8 + y + frame_no) % 4],
				gray[(x / 8 + y + frame_no) % 4]}, "pixel pair value wrong");
		end
		report("pixel data", start);
	endtask

	// ##################################################
	// Main sequence.
	// ##################################################
	initial begin
		logic [7:0] d;
		logic       c;
		int         start;
		int         gap;
		int         zeros;

		reset   = 1'b1;
		disp_on = 1'b0;
		void'($urandom(32'h463a2d18));
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Idle with the display off.
		start = all_fails();
		gap   = 16 + int'($urandom % 1024);
		for (int i = 0; i < gap; i++) begin
			@(negedge clk);
			expect_true(!lcd_write && lcd_cs && !lcd_read && lcd_vled == disp_on,
				"idle pins wrong");
		end
		report("idle", start);

		// Reset command.
		@(posedge clk);
		disp_on <= 1'b1;
		start = all_fails();
		next_write(16, d, c);
		expect_true(!c && d == `LCD_CMD_RESET, "first write is not the reset command");
		report("reset command", start);

		// RAM clear then the init ROM.
		start = all_fails();
		zeros = 0;
		next_write(16, d, c);
		while (c) begin
			expect_true(d == 8'h00, "RAM clear byte not zero");
			zeros++;
			next_write(LONG_WAIT, d, c);
		end
		expect_true(zeros > 0, "no RAM clear writes");
		for (int i = 0; i < 16; i++) begin
			if (i > 0) begin
				next_write(16, d, c);
			end
			expect_true(!c && d == rom[i], "init command wrong");
		end
		report("configuration", start);

		// Two full frames.
		for (int f = 0; f < 2; f++) begin
			check_readdress();
			check_pixels(`LCD_WIDTH * `LCD_HEIGHT / 2);
		end

		// Part of a third frame, then shutdown.
		check_readdress();
		check_pixels(100);
		@(posedge clk);
		disp_on <= 1'b0;
		start = all_fails();
		next_write(32, d, c);
		expect_true(!c && d == `LCD_CMD_RESET, "shutdown write is not the reset command");
		expect_true(!lcd_vled, "backlight still on");
		for (int i = 0; i < 2000; i++) begin
			@(negedge clk);
			expect_true(!lcd_write, "write after shutdown");
		end
		report("shutdown", start);

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (all_fails() == 0 && tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+common
common/lcd_pkg.sv
rtl/video_timing.sv
rtl/pattern_gen.sv
uc1611/uc1611_ctrl.sv
rtl/lcd_top.sv
verification/lcd_props.sv
verification/lcd_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module lcd_tb -o lcd_tb

run: compile
	./obj_dir/lcd_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
